//--- hdl/div_manager.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module div_manager (
  input  logic                   clk,
  input  logic                   reset,
  input  issue_pkg::issue_slot_t issue_i,
  output logic                   ready_o,
  input  issue_pkg::gpr_wb_t     wb_i,
  output issue_pkg::gpr_wb_t     wb_o
);

  import issue_pkg::*;

  localparam int LAT   = `DIV_LATENCY;
  localparam int CNT_W = $clog2(LAT + 1);

  // ---------------------------------------------------------------------------
  // latency tracking
  // ---------------------------------------------------------------------------

  logic                  busy_q;
  logic [CNT_W-1:0]      cnt_q;
  logic [`REG_IDX_W-1:0] dest_q;
  logic                  div_issue;
  logic                  lat_done;
  logic                  insert;

  assign div_issue = issue_i.valid && (issue_i.unit == UNIT_DIV);
  assign lat_done  = (cnt_q == '0);

  // result ready and channel free after fixed-point and i/o
  assign insert = busy_q && lat_done && !wb_i.we;

  // one divide at a time, slot in flight blocks as well
  assign ready_o = !busy_q && !div_issue;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      if (div_issue) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(LAT);
      end else begin
        if (busy_q && !lat_done) begin
          cnt_q <= cnt_q - 1'b1;
        end
        // leaves busy only once the wb is on the channel
        if (insert) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // destination of the divide in flight
  always_ff @(posedge clk) begin
    if (div_issue) begin
      dest_q <= issue_i.dest;
    end
  end

  // ---------------------------------------------------------------------------
  // write-back insertion, last stage of the chain
  // ---------------------------------------------------------------------------

  always_comb begin
    wb_o = wb_i;
    if (insert) begin
      wb_o.we   = 1'b1;
      wb_o.dest = dest_q;
      wb_o.src  = SRC_DIV;
    end
  end

  // scheduler respects ready, so nothing lands on a busy divider
  a_no_div_while_busy: assert property (
    @(posedge clk) disable iff (reset) div_issue |-> !busy_q
  );

  // divide result never before latency has run out
  a_div_wb_after_latency: assert property (
    @(posedge clk) disable iff (reset)
    div_issue |=> !insert [* LAT]
  );

endmodule

//--- hdl/inst_buffer.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module inst_buffer (
  input  logic             clk,
  input  logic             reset,
  input  logic             push_i,
  input  issue_pkg::inst_t push_inst_i,
  output logic             full_o,
  input  logic             pop_i,
  output issue_pkg::inst_t head_o,
  output logic             empty_o
);

  import issue_pkg::*;

  localparam int DEPTH = `BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ---------------------------------------------------------------------------
  // storage and pointers
  // ---------------------------------------------------------------------------

  inst_t             mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // wrap at depth, depth need not be a power of two
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_inst_i;
    end
  end

  // ---------------------------------------------------------------------------
  // status and head
  // ---------------------------------------------------------------------------

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  // head only meaningful while not empty
  assign head_o  = mem[rd_ptr];

  // scheduler must see the entry before taking it
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (reset) pop_i |-> !empty_o
  );

endmodule

//--- hdl/inst_receiver.sv
`timescale 1ns/1ps

module inst_receiver (
  input  logic             clk,
  input  logic             reset,
  input  logic             inst_req_i,
  input  issue_pkg::inst_t inst_i,
  output logic             inst_ack_o,
  input  logic             full_i,
  output logic             push_o,
  output issue_pkg::inst_t push_inst_o
);

  import issue_pkg::*;

  rcv_state_e state_q;
  rcv_state_e state_d;
  logic       accept;
  logic       push_q;
  inst_t      inst_q;

  // take a new request only with room in the buffer
  assign accept = (state_q == RCV_IDLE) && inst_req_i && !full_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RCV_IDLE: begin
        if (accept) begin
          state_d = RCV_ACK;
        end
      end
      RCV_ACK: begin
        // hold ack until requester lets go
        if (!inst_req_i) begin
          state_d = RCV_IDLE;
        end
      end
      default: state_d = RCV_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q <= RCV_IDLE;
      push_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // single push, same cycle ack goes high
      push_q  <= accept;
    end
  end

  // payload capture, inst_i is stable while req is high
  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
    end
  end

  assign inst_ack_o  = (state_q == RCV_ACK);
  assign push_o      = push_q;
  assign push_inst_o = inst_q;

  // buffer can only drain between the full check and the push
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (reset) push_o |-> !full_i
  );

endmodule

//--- hdl/io_wb_manager.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module io_wb_manager (
  input  logic                   clk,
  input  logic                   reset,
  input  issue_pkg::issue_slot_t issue_i,
  output logic                   ready_o,
  input  logic                   dwb_req_i,
  input  logic [`REG_IDX_W-1:0]  dwb_dest_i,
  input  logic                   dwb_cancel_i,
  output logic                   dwb_ack_o,
  input  issue_pkg::gpr_wb_t     wb_i,
  output issue_pkg::gpr_wb_t     wb_o
);

  import issue_pkg::*;

  logic outstanding_q;
  logic ack_q;
  logic io_issue;
  logic serve;
  logic insert;

  assign io_issue = issue_i.valid && (issue_i.unit == UNIT_IO);

  // new request, not yet acked
  // cancel needs no channel slot, so no wait for it
  assign serve  = dwb_req_i && !ack_q && (dwb_cancel_i || !wb_i.we);
  assign insert = serve && !dwb_cancel_i;

  // slot in flight counts as busy too
  assign ready_o = !outstanding_q && !io_issue;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      outstanding_q <= 1'b0;
      ack_q         <= 1'b0;
    end else begin
      if (io_issue) begin
        outstanding_q <= 1'b1;
      end else if (serve) begin
        outstanding_q <= 1'b0;
      end
      // ack rises after the serve cycle, drops once req is seen low
      ack_q <= dwb_req_i && (ack_q || serve);
    end
  end

  assign dwb_ack_o = ack_q;

  // ---------------------------------------------------------------------------
  // write-back insertion
  // ---------------------------------------------------------------------------

  always_comb begin
    wb_o = wb_i;
    if (insert) begin
      wb_o.we   = 1'b1;
      wb_o.dest = dwb_dest_i;
      wb_o.src  = SRC_IO;
    end
  end

  // fixed-point stage always wins over i/o
  a_io_keeps_upstream: assert property (
    @(posedge clk) disable iff (reset) wb_i.we |-> (wb_o == wb_i)
  );

endmodule

//--- hdl/issue_frontend.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module issue_frontend (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   inst_req_i,
  input  issue_pkg::inst_t       inst_i,
  output logic                   inst_ack_o,
  input  logic                   dwb_req_i,
  input  logic [`REG_IDX_W-1:0]  dwb_dest_i,
  input  logic                   dwb_cancel_i,
  output logic                   dwb_ack_o,
  output issue_pkg::issue_slot_t issue_o,
  output issue_pkg::gpr_wb_t     gpr_wb_o
);

  import issue_pkg::*;

  // ---------------------------------------------------------------------------
  // internal wiring
  // ---------------------------------------------------------------------------

  logic  buf_push;
  inst_t buf_push_inst;
  logic  buf_full;
  logic  buf_pop;
  inst_t buf_head;
  logic  buf_empty;
  logic  io_ready;
  logic  div_ready;
  // write-back chain, fixed -> i/o -> divide
  gpr_wb_t wb_fixed;
  gpr_wb_t wb_io;

  // producer side
  inst_receiver u_receiver (
    .clk         (clk),
    .reset       (reset),
    .inst_req_i  (inst_req_i),
    .inst_i      (inst_i),
    .inst_ack_o  (inst_ack_o),
    .full_i      (buf_full),
    .push_o      (buf_push),
    .push_inst_o (buf_push_inst)
  );

  inst_buffer u_buffer (
    .clk         (clk),
    .reset       (reset),
    .push_i      (buf_push),
    .push_inst_i (buf_push_inst),
    .full_o      (buf_full),
    .pop_i       (buf_pop),
    .head_o      (buf_head),
    .empty_o     (buf_empty)
  );

  // consumer side
  issue_scheduler u_scheduler (
    .clk         (clk),
    .reset       (reset),
    .head_i      (buf_head),
    .empty_i     (buf_empty),
    .pop_o       (buf_pop),
    .io_ready_i  (io_ready),
    .div_ready_i (div_ready),
    .issue_o     (issue_o),
    .fixed_wb_o  (wb_fixed)
  );

  io_wb_manager u_io_mgr (
    .clk          (clk),
    .reset        (reset),
    .issue_i      (issue_o),
    .ready_o      (io_ready),
    .dwb_req_i    (dwb_req_i),
    .dwb_dest_i   (dwb_dest_i),
    .dwb_cancel_i (dwb_cancel_i),
    .dwb_ack_o    (dwb_ack_o),
    .wb_i         (wb_fixed),
    .wb_o         (wb_io)
  );

  div_manager u_div_mgr (
    .clk     (clk),
    .reset   (reset),
    .issue_i (issue_o),
    .ready_o (div_ready),
    .wb_i    (wb_io),
    .wb_o    (gpr_wb_o)
  );

endmodule

//--- hdl/issue_params.svh
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// ---------------------------------------------------------------------------
// frontend sizing
// ---------------------------------------------------------------------------

// gpr index width, 32 registers
`define REG_IDX_W 5

// entries in the instruction buffer
`define BUF_DEPTH 2

// cycles from divide issue until result may be written
`define DIV_LATENCY 4

// issue slots: fixed-point, divide, i/o
`define NUM_UNITS 3

`endif

//--- hdl/issue_pkg.sv
`include "issue_params.svh"

package issue_pkg;

  // ---------------------------------------------------------------------------
  // opcodes and sources
  // ---------------------------------------------------------------------------

  // target unit of an instruction, also the slot index
  typedef enum logic [1:0] {
    UNIT_FIXED = 2'd0,
    UNIT_DIV   = 2'd1,
    UNIT_IO    = 2'd2
  } unit_e;

  // who owns a write-back channel stage
  typedef enum logic [1:0] {
    SRC_NONE  = 2'd0,
    SRC_FIXED = 2'd1,
    SRC_DIV   = 2'd2,
    SRC_IO    = 2'd3
  } wb_src_e;

  // receiver handshake states
  typedef enum logic {
    RCV_IDLE = 1'b0,
    RCV_ACK  = 1'b1
  } rcv_state_e;

  // ---------------------------------------------------------------------------
  // bundles
  // ---------------------------------------------------------------------------

  // instruction as received and buffered
  typedef struct packed {
    unit_e                 unit;
    logic [`REG_IDX_W-1:0] dest;
  } inst_t;

  // one issued instruction
  typedef struct packed {
    logic                  valid;
    unit_e                 unit;
    logic [`REG_IDX_W-1:0] dest;
  } issue_slot_t;

  // one stage of the gpr write-back chain
  typedef struct packed {
    logic                  we;
    logic [`REG_IDX_W-1:0] dest;
    wb_src_e               src;
  } gpr_wb_t;

endpackage

//--- hdl/issue_scheduler.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module issue_scheduler (
  input  logic                   clk,
  input  logic                   reset,
  input  issue_pkg::inst_t       head_i,
  input  logic                   empty_i,
  output logic                   pop_o,
  input  logic                   io_ready_i,
  input  logic                   div_ready_i,
  output issue_pkg::issue_slot_t issue_o,
  output issue_pkg::gpr_wb_t     fixed_wb_o
);

  import issue_pkg::*;

  logic [`NUM_UNITS-1:0] unit_ready;
  logic                  head_ready;
  logic                  valid_q;
  unit_e                 unit_q;
  logic [`REG_IDX_W-1:0] dest_q;

  // ---------------------------------------------------------------------------
  // slot readiness
  // ---------------------------------------------------------------------------

  // fixed-point never stalls
  always_comb begin
    unit_ready             = '0;
    unit_ready[UNIT_FIXED] = 1'b1;
    unit_ready[UNIT_DIV]   = div_ready_i;
    unit_ready[UNIT_IO]    = io_ready_i;
  end

  // unknown opcodes are never ready
  assign head_ready = (int'(head_i.unit) < `NUM_UNITS) ? unit_ready[head_i.unit] : 1'b0;

  // in-order, head blocks everything behind it
  assign pop_o = !empty_i && head_ready;

  // ---------------------------------------------------------------------------
  // registered issue slot
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      // at most one issue per cycle
      valid_q <= pop_o;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      unit_q <= head_i.unit;
      dest_q <= head_i.dest;
    end
  end

  assign issue_o.valid = valid_q;
  assign issue_o.unit  = unit_q;
  assign issue_o.dest  = dest_q;

  // fixed-point result goes out with its issue, head of the wb chain
  always_comb begin
    fixed_wb_o.we   = valid_q && (unit_q == UNIT_FIXED);
    fixed_wb_o.dest = dest_q;
    fixed_wb_o.src  = fixed_wb_o.we ? SRC_FIXED : SRC_NONE;
  end

  // every issued slot had a ready unit when popped
  a_issue_was_ready: assert property (
    @(posedge clk) disable iff (reset)
    issue_o.valid |->
      (issue_o.unit == UNIT_FIXED) ||
      (issue_o.unit == UNIT_DIV && $past(div_ready_i)) ||
      (issue_o.unit == UNIT_IO && $past(io_ready_i))
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_issue_frontend -o sim_issue_frontend

./obj_dir/sim_issue_frontend | tee sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  exit 1
fi
exit 0

//--- tb.f
+incdir+hdl
hdl/issue_pkg.sv
hdl/inst_receiver.sv
hdl/inst_buffer.sv
hdl/issue_scheduler.sv
hdl/io_wb_manager.sv
hdl/div_manager.sv
hdl/issue_frontend.sv
tb/tb_issue_frontend.sv

//--- tb/tb_issue_frontend.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module tb_issue_frontend;

  import issue_pkg::*;

  localparam int NUM_INST = 60;
  localparam int MAX_CYCLES = 40 * NUM_INST + 100;

  logic                  clk;
  logic                  reset;
  logic                  inst_req_i;
  inst_t                 inst_i;
  logic                  inst_ack_o;
  logic                  dwb_req_i;
  logic [`REG_IDX_W-1:0] dwb_dest_i;
  logic                  dwb_cancel_i;
  logic                  dwb_ack_o;
  issue_slot_t           issue_o;
  gpr_wb_t               gpr_wb_o;

  integer seed = 52;
  int     errors = 0;
  int     cycle = 0;
  bit     started = 0;
  inst_t  sent_q[$];
  int     fixed_cnt = 0;
  int     div_cnt = 0;
  int     io_nc_cnt = 0;
  int     wb_cnt = 0;
  int     io_wb_cnt = 0;
  bit     div_pending = 0;
  int     div_cyc;
  logic [`REG_IDX_W-1:0] div_dest;
  bit     io_pending = 0;

  issue_frontend dut (
    .clk          (clk),
    .reset        (reset),
    .inst_req_i   (inst_req_i),
    .inst_i       (inst_i),
    .inst_ack_o   (inst_ack_o),
    .dwb_req_i    (dwb_req_i),
    .dwb_dest_i   (dwb_dest_i),
    .dwb_cancel_i (dwb_cancel_i),
    .dwb_ack_o    (dwb_ack_o),
    .issue_o      (issue_o),
    .gpr_wb_o     (gpr_wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_mismatch(string name, int exp_val, int act_val);
    errors++;
    $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, exp_val, act_val);
  endtask

  task automatic report_failure(string what);
    errors++;
    $display("[ERROR] t=%0t %s", $time, what);
  endtask

  // ---------------------------------------------------------------------------
  // handshake and channel assertions
  // ---------------------------------------------------------------------------

  // quiet outputs until the first request
  a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
    !started |-> !inst_ack_o && !dwb_ack_o && !issue_o.valid && !gpr_wb_o.we)
    else report_failure("output active before the first request");
  // ack edges follow req as it was in the cycle before the edge
  a_ack_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(inst_ack_o) |-> $past(inst_req_i))
    else report_failure("inst ack rose without req");
  a_ack_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(inst_ack_o) |-> !$past(inst_req_i))
    else report_failure("inst ack fell while req high");
  a_dwb_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(dwb_ack_o) |-> $past(dwb_req_i))
    else report_failure("dwb ack rose without req");
  a_dwb_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(dwb_ack_o) |-> !$past(dwb_req_i))
    else report_failure("dwb ack fell while req high");
  // fixed-point result rides with its issue
  a_fixed_wb: assert property (@(posedge clk) disable iff (reset)
    (issue_o.valid && issue_o.unit == UNIT_FIXED) |->
    (gpr_wb_o.we && gpr_wb_o.src == SRC_FIXED))
    else report_failure("fixed-point issue without its write-back");
  a_fixed_dest: assert property (@(posedge clk) disable iff (reset)
    (issue_o.valid && issue_o.unit == UNIT_FIXED) |-> gpr_wb_o.dest == issue_o.dest)
    else report_mismatch("gpr_wb_o.dest", $sampled(issue_o.dest), $sampled(gpr_wb_o.dest));

  // ---------------------------------------------------------------------------
  // monitor, reference queues
  // ---------------------------------------------------------------------------

  always @(posedge clk) begin
    inst_t exp_inst;
    if (!reset) begin
      if (gpr_wb_o.we) begin
        wb_cnt++;
        if (gpr_wb_o.src == SRC_DIV) begin
          assert (div_pending) else report_failure("divide write-back with no divide");
          assert (gpr_wb_o.dest == div_dest)
            else report_mismatch("gpr_wb_o.dest", div_dest, gpr_wb_o.dest);
          assert (cycle - div_cyc >= `DIV_LATENCY)
            else report_mismatch("divide latency", `DIV_LATENCY, cycle - div_cyc);
          div_pending = 0;
        end
        if (gpr_wb_o.src == SRC_IO) begin
          io_wb_cnt++;
          assert (dwb_req_i && !dwb_ack_o && !dwb_cancel_i)
            else report_failure("i/o write-back outside an open request");
          assert (gpr_wb_o.dest == dwb_dest_i)
            else report_mismatch("gpr_wb_o.dest", dwb_dest_i, gpr_wb_o.dest);
        end
      end
      if (issue_o.valid) begin
        if (sent_q.size() == 0) begin
          report_failure("issue with nothing sent");
        end else begin
          exp_inst = sent_q.pop_front();
          assert (issue_o.unit == exp_inst.unit)
            else report_mismatch("issue_o.unit", exp_inst.unit, issue_o.unit);
          assert (issue_o.dest == exp_inst.dest)
            else report_mismatch("issue_o.dest", exp_inst.dest, issue_o.dest);
        end
        case (issue_o.unit)
          UNIT_FIXED: fixed_cnt++;
          UNIT_DIV: begin
            assert (!div_pending) else report_failure("divide issued while one outstanding");
            div_pending = 1;
            div_dest = issue_o.dest;
            div_cyc = cycle;
            div_cnt++;
          end
          default: begin
            assert (!io_pending) else report_failure("i/o issued while one outstanding");
            io_pending = 1;
          end
        endcase
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the frontend did not drain", cycle);
      $display("sim failed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------

  task automatic send_inst(inst_t inst);
    sent_q.push_back(inst);
    started = 1;
    inst_i = inst;
    inst_req_i = 1'b1;
    do @(posedge clk); while (!inst_ack_o);
    #1 inst_req_i = 1'b0;
    do @(posedge clk); while (inst_ack_o);
    #1;
  endtask

  // one delayed request per i/o issue
  task automatic answer_io();
    int  wait_cyc;
    int  seen_before;
    bit  cancel;
    wait_cyc = {$random(seed)} % 6;
    cancel = ({$random(seed)} % 4) == 0;
    repeat (wait_cyc) @(posedge clk);
    #1;
    seen_before = io_wb_cnt;
    dwb_dest_i = $random(seed);
    dwb_cancel_i = cancel;
    dwb_req_i = 1'b1;
    do @(posedge clk); while (!dwb_ack_o);
    #1;
    assert (io_wb_cnt - seen_before == (cancel ? 0 : 1))
      else report_mismatch("i/o write-back count", cancel ? 0 : 1, io_wb_cnt - seen_before);
    if (!cancel) io_nc_cnt++;
    io_pending = 0;
    dwb_req_i = 1'b0;
    do @(posedge clk); while (dwb_ack_o);
    #1 dwb_cancel_i = 1'b0;
  endtask

  initial begin
    forever begin
      @(posedge clk);
      if (io_pending && !dwb_req_i) answer_io();
    end
  end

  initial begin
    inst_t inst;
    int    err_mark;
    reset = 1'b1;
    inst_req_i = 1'b0;
    inst_i = '0;
    dwb_req_i = 1'b0;
    dwb_dest_i = '0;
    dwb_cancel_i = 1'b0;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    $display("test reset_quiet done, errors %0d", errors);
    err_mark = errors;
    for (int i = 0; i < NUM_INST; i++) begin
      inst.unit = unit_e'({$random(seed)} % 3);
      inst.dest = $random(seed);
      send_inst(inst);
    end
    while (sent_q.size() != 0 || div_pending || io_pending || dwb_req_i) @(posedge clk);
    repeat (10) @(posedge clk);
    $display("test instruction_stream done, errors %0d", errors - err_mark);
    err_mark = errors;
    assert (wb_cnt == fixed_cnt + div_cnt + io_nc_cnt)
      else report_mismatch("write-back total", fixed_cnt + div_cnt + io_nc_cnt, wb_cnt);
    $display("test writeback_totals done, errors %0d", errors - err_mark);
    $display("tests 3, fixed %0d, divide %0d, i/o written %0d, write-backs %0d, errors %0d",
             fixed_cnt, div_cnt, io_nc_cnt, wb_cnt, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
